// ==== nic_switch.f ====
hdl/nic_switch_pkg.sv
hdl/ingress_arbiter.sv
hdl/meta_stamper.sv
hdl/egress_demux.sv
hdl/nic_switch.sv
bench/clock_gen.sv
bench/nic_checker.sv
bench/tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the nic_switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb -f nic_switch.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

// ==== bench/tb.sv ====
`default_nettype none

module tb;
    import nic_switch_pkg::*;

    localparam int SEED        = 17;
    localparam int DRIVE_DLY   = 10;
    localparam int MAX_BEATS   = 8;
    localparam int WAIT_LIMIT  = 4000;
    localparam int IDLE_CYCLES = 20;

    logic       axis_clk;
    logic       rst_n;
    axis_beat_t in_beat   [NUM_PORTS];
    logic       in_valid  [NUM_PORTS];
    logic       in_ready  [NUM_PORTS];
    axis_beat_t out_beat  [NUM_PORTS];
    logic       out_valid [NUM_PORTS];
    logic       out_ready [NUM_PORTS];
    logic       fair_en;
    logic       bp_mode;
    logic       timed_out;
    int         err_count;
    int         pending;
    int         tests_run;
    int         tests_failed;
    int         start_errs;

    clock_gen #(.PERIOD(100), .RST_CYCLES(3)) clk_i (.axis_clk(axis_clk), .rst_n(rst_n));

    nic_switch #(.NUM_PORTS(NUM_PORTS)) dut_i (
        .axis_clk  (axis_clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    nic_checker #(.NUM_PORTS(NUM_PORTS)) chk_i (
        .axis_clk  (axis_clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .fair_en   (fair_en),
        .err_count (err_count),
        .pending   (pending)
    );

    // Output ready redrawn every cycle in the back-pressure test
    always @(posedge axis_clk) begin
        #DRIVE_DLY;
        for (int d = 0; d < NUM_PORTS; d++) begin
            out_ready[d] = bp_mode ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    task automatic send_packet(input int p);
        int    len;
        int    waited;
        port_t dest;
        logic  accepted;
        len  = 1 + ($urandom % MAX_BEATS);
        dest = port_t'($urandom % NUM_PORTS);
        for (int b = 0; b < len && !timed_out; b++) begin
            in_beat[p]       = '0;
            in_beat[p].data  = {$urandom, $urandom};
            in_beat[p].keep  = '1;
            in_beat[p].last  = (b == len - 1);
            in_beat[p].tdest = dest;
            if (b == len - 1) begin
                in_beat[p].keep = {DATA_BYTES{1'b1}} >> ($urandom % DATA_BYTES);
            end
            in_valid[p] = 1'b1;
            accepted    = 1'b0;
            waited      = 0;
            while (!accepted && !timed_out) begin
                @(posedge axis_clk);
                accepted = in_ready[p];
                waited++;
                if (!accepted && waited > WAIT_LIMIT) begin
                    $display("timeout: input port %0d never saw in_ready", p);
                    timed_out = 1'b1;
                end
            end
            #DRIVE_DLY;
        end
    endtask

    task automatic send_stream(input int p, input int count);
        for (int n = 0; n < count && !timed_out; n++) begin
            send_packet(p);
        end
        in_valid[p] = 1'b0;
    endtask

    task automatic send_all(input int count);
        fork
            send_stream(0, count);
            send_stream(1, count);
            send_stream(2, count);
            send_stream(3, count);
        join
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending != 0 && !timed_out) begin
            @(posedge axis_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: %0d expected beats never left the switch", pending);
                timed_out = 1'b1;
            end
        end
        repeat (4) @(posedge axis_clk);
        #DRIVE_DLY;
    endtask

    task automatic close_test(input string name, input int first_err);
        tests_run++;
        if (err_count != first_err || timed_out) begin
            tests_failed++;
        end
        $display("test %-10s %s, %0d errors", name,
                 (err_count == first_err && !timed_out) ? "passed" : "failed",
                 err_count - first_err);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        int waited;
        void'($urandom(SEED));
        timed_out    = 1'b0;
        fair_en      = 1'b0;
        bp_mode      = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        waited       = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_beat[p]   = '0;
            in_valid[p]  = 1'b0;
            out_ready[p] = 1'b1;
        end

        // Outputs stay quiet after reset with no traffic
        start_errs = err_count;
        while (!rst_n && !timed_out) begin
            @(posedge axis_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: reset was never released");
                timed_out = 1'b1;
            end
        end
        repeat (IDLE_CYCLES) @(posedge axis_clk);
        #DRIVE_DLY;
        close_test("reset", start_errs);

        start_errs = err_count;
        for (int p = 0; p < NUM_PORTS && !timed_out; p++) begin
            send_stream(p, 12);
            wait_drain();
        end
        close_test("routing", start_errs);

        start_errs = err_count;
        send_all(40);
        wait_drain();
        close_test("contention", start_errs);

        // Long enough to carry the sequence counters past their wrap
        start_errs = err_count;
        bp_mode = 1'b1;
        send_all(220);
        bp_mode = 1'b0;
        wait_drain();
        close_test("backpress", start_errs);

        start_errs = err_count;
        fair_en = 1'b1;
        send_all(6);
        wait_drain();
        fair_en = 1'b0;
        close_test("fairness", start_errs);

        $display("tests run %0d, failed %0d, error count %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb

`default_nettype wire

// ==== bench/nic_checker.sv ====
`default_nettype none

module nic_checker #(
    parameter int NUM_PORTS = nic_switch_pkg::NUM_PORTS
) (
    input  logic                       axis_clk,
    input  logic                       rst_n,
    input  nic_switch_pkg::axis_beat_t in_beat   [NUM_PORTS],
    input  logic                       in_valid  [NUM_PORTS],
    input  logic                       in_ready  [NUM_PORTS],
    input  nic_switch_pkg::axis_beat_t out_beat  [NUM_PORTS],
    input  logic                       out_valid [NUM_PORTS],
    input  logic                       out_ready [NUM_PORTS],
    input  logic                       fair_en,
    output int                         err_count,
    output int                         pending
);
    import nic_switch_pkg::*;

    // Expected beats, by source then destination
    axis_beat_t exp_q     [NUM_PORTS][NUM_PORTS][$];
    int         pkt_cnt   [NUM_PORTS];
    int         fair_cnt  [NUM_PORTS];
    logic       in_pkt    [NUM_PORTS];
    port_t      cur_src   [NUM_PORTS];
    logic       held      [NUM_PORTS];
    axis_beat_t held_beat [NUM_PORTS];
    logic       seen_input;

    initial begin
        err_count  = 0;
        pending    = 0;
        seen_input = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            pkt_cnt[i]  = 0;
            fair_cnt[i] = 0;
            in_pkt[i]   = 1'b0;
            cur_src[i]  = '0;
            held[i]     = 1'b0;
        end
    end

    task automatic beat_mismatch(input string sig, input axis_beat_t want, input axis_beat_t got);
        $display("error at %0t: %s expected %h actual %h", $time, sig, want, got);
        err_count++;
    endtask

    task automatic flag_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        err_count++;
    endtask

    // ==================================================
    // Reference model, input side
    // ==================================================

    task automatic take_inputs();
        axis_beat_t want;
        for (int s = 0; s < NUM_PORTS; s++) begin
            if (!fair_en) begin
                fair_cnt[s] = 0;
            end
            if (in_valid[s] && in_ready[s]) begin
                seen_input    = 1'b1;
                want          = in_beat[s];
                want.tid      = port_t'(s);
                want.user.src = port_t'(s);
                // Running packet count of this source, modulo the counter range
                want.user.seq = SEQ_WID'(pkt_cnt[s] % (1 << SEQ_WID));
                exp_q[s][in_beat[s].tdest].push_back(want);
                if (in_beat[s].last) begin
                    pkt_cnt[s]++;
                    if (fair_en) begin
                        fair_cnt[s]++;
                        for (int j = 0; j < NUM_PORTS; j++) begin
                            if (fair_cnt[s] == 2 && fair_cnt[j] == 0) begin
                                flag_failure($sformatf(
                                    "port %0d got a second packet before port %0d got one", s, j));
                            end
                        end
                    end
                end
            end
        end
    endtask

    // ==================================================
    // Output side
    // ==================================================

    task automatic compare_beat(input int d);
        axis_beat_t want;
        port_t      src;
        // A packet in progress locks its source until last
        src = in_pkt[d] ? cur_src[d] : out_beat[d].tid;
        if (exp_q[src][d].size() == 0) begin
            flag_failure($sformatf("output %0d sent a beat that no packet from port %0d explains",
                                   d, src));
        end else begin
            want = exp_q[src][d].pop_front();
            if (out_beat[d] != want) begin
                beat_mismatch($sformatf("out_beat[%0d]", d), want, out_beat[d]);
            end
        end
        in_pkt[d]  = !out_beat[d].last;
        cur_src[d] = src;
    endtask

    task automatic check_outputs();
        for (int d = 0; d < NUM_PORTS; d++) begin
            if (!seen_input && out_valid[d]) begin
                flag_failure($sformatf("out_valid[%0d] went high before any input", d));
            end
            // Stalled beat must stay put
            if (held[d]) begin
                if (!out_valid[d]) begin
                    flag_failure($sformatf("out_valid[%0d] dropped while out_ready was low", d));
                end else if (out_beat[d] != held_beat[d]) begin
                    beat_mismatch($sformatf("out_beat[%0d] during stall", d),
                                  held_beat[d], out_beat[d]);
                end
            end
            held[d]      = out_valid[d] && !out_ready[d];
            held_beat[d] = out_beat[d];
            if (out_valid[d] && out_ready[d]) begin
                compare_beat(d);
            end
        end
    endtask

    function automatic int queued_beats();
        int total;
        total = 0;
        for (int s = 0; s < NUM_PORTS; s++) begin
            for (int d = 0; d < NUM_PORTS; d++) begin
                total += exp_q[s][d].size();
            end
        end
        return total;
    endfunction

    always @(posedge axis_clk) begin
        if (rst_n) begin
            take_inputs();
            check_outputs();
            pending = queued_beats();
        end
    end

endmodule : nic_checker

`default_nettype wire

// ==== bench/clock_gen.sv ====
`default_nettype none

module clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 3
) (
    output logic axis_clk,
    output logic rst_n
);

    initial begin
        axis_clk = 1'b0;
        forever #(PERIOD / 2) axis_clk = ~axis_clk;
    end

    // Release a little after a rising edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge axis_clk);
        #(PERIOD / 10) rst_n = 1'b1;
    end

endmodule : clock_gen

`default_nettype wire

// ==== hdl/nic_switch.sv ====
`default_nettype none

module nic_switch #(
    parameter int NUM_PORTS = nic_switch_pkg::NUM_PORTS
) (
    input  logic                       axis_clk,
    input  logic                       rst_n,
    input  nic_switch_pkg::axis_beat_t in_beat   [NUM_PORTS],
    input  logic                       in_valid  [NUM_PORTS],
    output logic                       in_ready  [NUM_PORTS],
    output nic_switch_pkg::axis_beat_t out_beat  [NUM_PORTS],
    output logic                       out_valid [NUM_PORTS],
    input  logic                       out_ready [NUM_PORTS]
);
    import nic_switch_pkg::*;

    // ==================================================
    // Stage links
    // ==================================================

    axis_beat_t arb_beat;
    logic       arb_valid;
    logic       arb_ready;
    port_t      arb_src;

    axis_beat_t stamp_beat;
    logic       stamp_valid;
    logic       stamp_ready;

    // Packet-granular round robin over the four inputs
    ingress_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) arb_i (
        .axis_clk  (axis_clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .arb_beat  (arb_beat),
        .arb_valid (arb_valid),
        .arb_ready (arb_ready),
        .arb_src   (arb_src)
    );

    // Source port and sequence number into tid and tuser
    meta_stamper #(
        .NUM_PORTS (NUM_PORTS)
    ) stamp_i (
        .axis_clk    (axis_clk),
        .rst_n       (rst_n),
        .arb_beat    (arb_beat),
        .arb_valid   (arb_valid),
        .arb_ready   (arb_ready),
        .arb_src     (arb_src),
        .stamp_beat  (stamp_beat),
        .stamp_valid (stamp_valid),
        .stamp_ready (stamp_ready)
    );

    // Steer by tdest
    egress_demux #(
        .NUM_PORTS (NUM_PORTS)
    ) demux_i (
        .axis_clk    (axis_clk),
        .rst_n       (rst_n),
        .stamp_beat  (stamp_beat),
        .stamp_valid (stamp_valid),
        .stamp_ready (stamp_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule : nic_switch

`default_nettype wire

// ==== hdl/egress_demux.sv ====
`default_nettype none

module egress_demux #(
    parameter int NUM_PORTS = nic_switch_pkg::NUM_PORTS
) (
    input  logic                       axis_clk,
    input  logic                       rst_n,
    input  nic_switch_pkg::axis_beat_t stamp_beat,
    input  logic                       stamp_valid,
    output logic                       stamp_ready,
    output nic_switch_pkg::axis_beat_t out_beat  [NUM_PORTS],
    output logic                       out_valid [NUM_PORTS],
    input  logic                       out_ready [NUM_PORTS]
);
    import nic_switch_pkg::*;

    // ==================================================
    // Destination decode
    // ==================================================

    // Ports 0 and 1 are MAC egress, 2 and 3 card-to-host
    port_t                target;
    logic                 accept;
    logic [NUM_PORTS-1:0] load_vec;
    logic [NUM_PORTS-1:0] vld_q;

    assign target = stamp_beat.tdest;

    // Only the addressed register matters, the others may stay full
    assign stamp_ready = !vld_q[target] || out_ready[target];
    assign accept      = stamp_valid && stamp_ready;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            load_vec[i] = accept && (target == port_t'(i));
        end
    end

    // ==================================================
    // Per-port output registers
    // ==================================================

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (load_vec[i]) begin
                    vld_q[i] <= 1'b1;
                end else if (out_ready[i]) begin
                    vld_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (load_vec[i]) begin
                out_beat[i] <= stamp_beat;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            out_valid[i] = vld_q[i];
        end
    end

    // One input beat never lights two outputs
    single_rise_a : assert property (
        @(posedge axis_clk) disable iff (!rst_n)
        $onehot0(vld_q & ~$past(vld_q))
    );

endmodule : egress_demux

`default_nettype wire

// ==== hdl/meta_stamper.sv ====
`default_nettype none

module meta_stamper #(
    parameter int NUM_PORTS = nic_switch_pkg::NUM_PORTS
) (
    input  logic                       axis_clk,
    input  logic                       rst_n,
    input  nic_switch_pkg::axis_beat_t arb_beat,
    input  logic                       arb_valid,
    output logic                       arb_ready,
    input  nic_switch_pkg::port_t      arb_src,
    output nic_switch_pkg::axis_beat_t stamp_beat,
    output logic                       stamp_valid,
    input  logic                       stamp_ready
);
    import nic_switch_pkg::*;

    // ==================================================
    // Sequence counters, one per source
    // ==================================================

    logic [SEQ_WID-1:0] seq_cnt [NUM_PORTS];
    logic               accept;
    axis_beat_t         stamped;

    assign arb_ready = !stamp_valid || stamp_ready;
    assign accept    = arb_valid && arb_ready;

    // Count moves only on last, so a packet keeps one number
    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                seq_cnt[i] <= '0;
            end
        end else if (accept && arb_beat.last) begin
            seq_cnt[arb_src] <= seq_cnt[arb_src] + 1'b1;
        end
    end

    always_comb begin
        stamped          = arb_beat;
        stamped.tid      = arb_src;
        stamped.user.src = arb_src;
        stamped.user.seq = seq_cnt[arb_src];
    end

    // ==================================================
    // Output register
    // ==================================================

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            stamp_valid <= 1'b0;
        end else if (arb_ready) begin
            stamp_valid <= arb_valid;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            stamp_beat <= stamped;
        end
    end

    // tid and the tuser source field describe the same port, and the number
    // shown is the one that source's counter handed out
    src_match_a : assert property (
        @(posedge axis_clk) disable iff (!rst_n)
        stamp_valid |-> (stamp_beat.tid == stamp_beat.user.src)
            && (seq_cnt[stamp_beat.user.src]
                == stamp_beat.user.seq + SEQ_WID'(stamp_beat.last))
    );

endmodule : meta_stamper

`default_nettype wire

// ==== hdl/ingress_arbiter.sv ====
`default_nettype none

module ingress_arbiter #(
    parameter int NUM_PORTS = nic_switch_pkg::NUM_PORTS
) (
    input  logic                       axis_clk,
    input  logic                       rst_n,
    input  nic_switch_pkg::axis_beat_t in_beat   [NUM_PORTS],
    input  logic                       in_valid  [NUM_PORTS],
    output logic                       in_ready  [NUM_PORTS],
    output nic_switch_pkg::axis_beat_t arb_beat,
    output logic                       arb_valid,
    input  logic                       arb_ready,
    output nic_switch_pkg::port_t      arb_src
);
    import nic_switch_pkg::*;

    // ==================================================
    // State
    // ==================================================

    arb_state_t state;
    port_t      rr_ptr;
    port_t      grant;
    logic       run;

    port_t pick;
    logic  pick_ok;
    port_t sel;
    logic  sel_ok;
    logic  space;
    logic  take;

    // Inputs stay blocked for one cycle after reset release
    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // First valid port at or after the pointer
    always_comb begin
        pick = rr_ptr;
        pick_ok = 1'b0;
        // Walk backwards so the nearest port wins
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            if (in_valid[(int'(rr_ptr) + k) % NUM_PORTS]) begin
                pick = port_t'((int'(rr_ptr) + k) % NUM_PORTS);
                pick_ok = 1'b1;
            end
        end
    end

    assign sel    = (state == ARB_IDLE) ? pick : grant;
    assign sel_ok = (state == ARB_IDLE) ? pick_ok : 1'b1;
    assign space  = !arb_valid || arb_ready;
    assign take   = run && space && sel_ok && in_valid[sel];

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_ready[i] = run && space && sel_ok && (sel == port_t'(i));
        end
    end

    // ==================================================
    // Grant FSM
    // ==================================================

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ARB_IDLE;
            rr_ptr <= '0;
            grant  <= '0;
        end else if (take) begin
            if (in_beat[sel].last) begin
                // Packet done, next search starts past this port
                state  <= ARB_IDLE;
                rr_ptr <= port_t'((int'(sel) + 1) % NUM_PORTS);
            end else begin
                state <= ARB_PKT;
                grant <= sel;
            end
        end
    end

    // ==================================================
    // Output register
    // ==================================================

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            arb_valid <= 1'b0;
        end else if (space) begin
            arb_valid <= take;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (take) begin
            arb_beat <= in_beat[sel];
            arb_src  <= sel;
        end
    end

    // Source of the packet now leaving the output register
    logic  out_open;
    port_t out_src;

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_open <= 1'b0;
            out_src  <= '0;
        end else if (arb_valid && arb_ready) begin
            out_open <= !arb_beat.last;
            out_src  <= arb_src;
        end
    end

    // The grant holds for a whole packet, so its beats leave with one source
    grant_hold_a : assert property (
        @(posedge axis_clk) disable iff (!rst_n)
        (arb_valid && out_open) |-> (arb_src == out_src)
    );

endmodule : ingress_arbiter

`default_nettype wire

// ==== hdl/nic_switch_pkg.sv ====
`default_nettype none

package nic_switch_pkg;

    // ==================================================
    // Widths
    // ==================================================

    // Two MAC ingress ports plus two host-to-card ports
    localparam int NUM_PORTS = 4;

    // Port index, also the width of tid and tdest
    localparam int PORT_WID = 2;

    // Beat width, cut down from the 512-bit datapath
    localparam int DATA_BYTES = 8;
    localparam int DATA_WID = DATA_BYTES * 8;

    // Per-source packet sequence number, wraps
    localparam int SEQ_WID = 8;

    // ==================================================
    // Types
    // ==================================================

    typedef logic [PORT_WID-1:0] port_t;

    // Metadata carried in tuser on the switch outputs
    typedef struct packed {
        logic [SEQ_WID-1:0] seq;
        port_t              src;
    } switch_meta_t;

    // One stream beat, valid and ready travel beside it
    typedef struct packed {
        logic [DATA_WID-1:0]   data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        port_t                 tid;
        port_t                 tdest;
        switch_meta_t          user;
    } axis_beat_t;

    // Arbiter holds a grant for a whole packet
    typedef enum logic {
        ARB_IDLE,
        ARB_PKT
    } arb_state_t;

endpackage : nic_switch_pkg

`default_nettype wire
